//--- Bender.yml
package:
  name: monster_fleet

sources:
  # Packages first, the RTL modules import them
  - files:
      - logic/displayPkg.sv
      - logic/fleetPkg.sv
      - logic/monsterMotion.sv
      - logic/monsterSprite.sv
      - logic/monsterGun.sv
      - logic/fleetArbiter.sv
      - logic/monsterFleet.sv
  - target: simulation
    files:
      - dv/fleetTb.sv

//--- dv/fleetTb.sv
// Runs the default fleet with no border hits, so monsters only drift right and down after joining
`timescale 1ns/1ps

module fleetTb;
    import displayPkg::*;
    import fleetPkg::*;

    localparam int fleetSize = 4;
    localparam int speed = 2;
    localparam int boomFrames = 3;
    localparam int cooldownBase = 6;
    localparam int fallSpeed = 4;
    // Roughly four times the cycles the sequence below needs
    localparam int timeoutCycles = 4000;

    logic        clk;
    logic        resetN;
    logic        enable;
    logic        startOfFrame;
    coordinate   pixelX;
    coordinate   pixelY;
    stageNum     stage;
    collisionVec collision;
    drawOut      monsterOut;
    drawOut      missileOut;
    logic        monsterDied;
    logic        allDead;

    // Expected response to the pixel driven in this cycle
    logic checking;
    logic expMonDraw;
    rgb   expMonColor;
    logic expMisDraw;
    logic killStrike;
    logic expAllDead;

    // Reference model of the fleet
    logic armed;
    int   posX [fleetSize];
    int   posY [fleetSize];
    logic hitM [fleetSize];
    logic spentM [fleetSize];
    int   boomLeft [fleetSize];
    int   cdLeft [fleetSize];
    logic flying [fleetSize];
    int   misX [fleetSize];
    int   misY [fleetSize];

    int          errorCount;
    int          probeCount;
    int unsigned rngState;

    monsterFleet monsterFleet_inst (
        .clk         (clk),
        .resetN      (resetN),
        .enable      (enable),
        .startOfFrame(startOfFrame),
        .pixelX      (pixelX),
        .pixelY      (pixelY),
        .stage       (stage),
        .collision   (collision),
        .monsterOut  (monsterOut),
        .missileOut  (missileOut),
        .monsterDied (monsterDied),
        .allDead     (allDead)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int stageSize(input stageNum s);
        case (s)
            2'd1: return 2;
            2'd2: return 4;
            2'd3: return 3;
            default: return 0;
        endcase
    endfunction

    function automatic logic isActive(input int i);
        return armed && (i < stageSize(stage)) && !spentM[i];
    endfunction

    function automatic int unsigned lcgNext();
        rngState = rngState * 32'd1103515245 + 32'd12345;
        return rngState >> 16;
    endfunction

    // Lowest index wins where sprites overlap
    function automatic drawOut monsterAt(input int x, input int y);
        drawOut result;
        int     dx;
        int     dy;
        logic   edgeX;
        logic   edgeY;
        result = '{drawReq: 1'b0, color: aliveColor};
        for (int i = fleetSize - 1; i >= 0; i--) begin
            dx = x - posX[i];
            dy = y - posY[i];
            edgeX = (dx < 2) || (dx >= monsterW - 2);
            edgeY = (dy < 2) || (dy >= monsterH - 2);
            if (isActive(i) && x < 640 && y < 480 && dx >= 0 && dx < monsterW && dy >= 0
                    && dy < monsterH && !(edgeX && edgeY)) begin
                result.drawReq = 1'b1;
                result.color = hitM[i] ? explodeColor : aliveColor;
            end
        end
        return result;
    endfunction

    function automatic logic missileAt(input int x, input int y);
        logic found;
        found = 1'b0;
        for (int i = 0; i < fleetSize; i++) begin
            if (flying[i] && x >= misX[i] && x < misX[i] + 2 && y >= misY[i] && y < misY[i] + 6) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #5;
    endtask

    task automatic flagError(input string msg);
        errorCount++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    task automatic probe(input int x, input int y);
        drawOut mon;
        mon = monsterAt(x, y);
        pixelX = coordinate'(x);
        pixelY = coordinate'(y);
        expMonDraw = mon.drawReq;
        expMonColor = mon.color;
        expMisDraw = missileAt(x, y);
        checking = 1'b1;
        probeCount++;
        nextCycle();
    endtask

    // Off-screen pixel, nothing may ever draw here
    task automatic park();
        pixelX = 11'd2000;
        pixelY = 11'd2000;
        expMonDraw = 1'b0;
        expMisDraw = 1'b0;
    endtask

    task automatic refreshAllDead();
        logic anyActive;
        anyActive = 1'b0;
        for (int i = 0; i < fleetSize; i++) begin
            anyActive = anyActive | isActive(i);
        end
        expAllDead = (stageSize(stage) != 0) && !anyActive;
    endtask

    task automatic advanceModel();
        logic wasFlying;
        for (int i = 0; i < fleetSize; i++) begin
            wasFlying = flying[i];
            // A missile keeps falling even after its monster is gone
            if (flying[i]) begin
                misY[i] += fallSpeed;
                if (misY[i] >= 480) begin
                    flying[i] = 1'b0;
                end
            end
            if (!isActive(i)) begin
                cdLeft[i] = cooldownBase + 2 * i;
            end else begin
                cdLeft[i]--;
                if (cdLeft[i] == 0) begin
                    cdLeft[i] = cooldownBase + 2 * i;
                    // Launched from the spot held before this frame's step
                    if (!hitM[i] && !wasFlying) begin
                        flying[i] = 1'b1;
                        misX[i] = posX[i] + monsterW / 2 - 1;
                        misY[i] = posY[i] + monsterH;
                    end
                end
                if (hitM[i]) begin
                    boomLeft[i]--;
                    spentM[i] = (boomLeft[i] == 0);
                end else begin
                    posX[i] += speed;
                    posY[i] += speed;
                end
            end
        end
    endtask

    task automatic runFrame();
        park();
        startOfFrame = 1'b1;
        armed = armed | (stageSize(stage) != 0);
        refreshAllDead();
        nextCycle();
        startOfFrame = 1'b0;
        if (enable) begin
            advanceModel();
        end
        refreshAllDead();
    endtask

    task automatic strike(input int idx);
        int x;
        int y;
        x = posX[idx] + monsterW / 2;
        y = posY[idx] + monsterH / 2;
        probe(x, y);
        probe(x, y);
        // monsterOut shows this pixel now, so the detector blames monster idx
        checking = 1'b0;
        collision.missileHit = 1'b1;
        killStrike = !hitM[idx];
        nextCycle();
        collision.missileHit = 1'b0;
        killStrike = 1'b0;
        if (!hitM[idx]) begin
            hitM[idx] = 1'b1;
            boomLeft[idx] = boomFrames;
        end
        probe(x, y);
        probe(x, y);
    endtask

    task automatic checkMonster(input int i);
        int unsigned r;
        for (int n = 0; n < 3; n++) begin
            r = lcgNext();
            probe(posX[i] + 2 + int'(r % 12), posY[i] + int'((r >> 4) % 12));
        end
        probe(posX[i], posY[i]);
        probe(posX[i] + monsterW - 1, posY[i] + monsterH - 1);
        probe(posX[i] + monsterW, posY[i] + 5);
        probe(initialX + i * spacingX + 2, initialY + 2);
    endtask

    // Without a missile in flight this probes where a launch would put one
    task automatic checkMissile(input int i);
        int x;
        int y;
        x = flying[i] ? misX[i] : posX[i] + monsterW / 2 - 1;
        y = flying[i] ? misY[i] : posY[i] + monsterH;
        probe(x, y);
        probe(x + 1, y + 5);
        probe(x + 2, y + 1);
        probe(x, y + 6);
    endtask

    task automatic checkFleet();
        for (int i = 0; i < fleetSize; i++) begin
            checkMonster(i);
            checkMissile(i);
        end
    endtask

    monsterDrawMatches: assert property (@(posedge clk) disable iff (!resetN)
        $past(checking, 2) |-> monsterOut.drawReq == $past(expMonDraw, 2))
        else flagError("monsterOut draw request differs from the model");

    monsterColorMatches: assert property (@(posedge clk) disable iff (!resetN)
        $past(checking, 2) && $past(expMonDraw, 2) |-> monsterOut.color == $past(expMonColor, 2))
        else flagError("monsterOut colour differs from the model");

    missileDrawMatches: assert property (@(posedge clk) disable iff (!resetN)
        $past(checking) |-> missileOut.drawReq == $past(expMisDraw))
        else flagError("missileOut draw request differs from the model");

    missileColorMatches: assert property (@(posedge clk) disable iff (!resetN)
        missileOut.drawReq |-> missileOut.color == missileColor)
        else flagError("missileOut colour is not the missile colour");

    // One pulse, two cycles after the blamed collision
    diedPulseMatches: assert property (@(posedge clk) disable iff (!resetN)
        monsterDied == $past(killStrike, 2))
        else flagError("monsterDied pulse differs from the model");

    allDeadMatches: assert property (@(posedge clk) disable iff (!resetN)
        allDead == expAllDead)
        else flagError("allDead differs from the model");

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < timeoutCycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the stimulus never finished", cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        rngState = 32'd61419;
        errorCount = 0;
        probeCount = 0;
        resetN = 1'b0;
        enable = 1'b0;
        startOfFrame = 1'b0;
        stage = 2'd0;
        collision = '0;
        checking = 1'b0;
        expMonColor = aliveColor;
        killStrike = 1'b0;
        armed = 1'b0;
        for (int i = 0; i < fleetSize; i++) begin
            posX[i] = initialX + i * spacingX;
            posY[i] = initialY;
            hitM[i] = 1'b0;
            spentM[i] = 1'b0;
            boomLeft[i] = 0;
            cdLeft[i] = cooldownBase + 2 * i;
            flying[i] = 1'b0;
            misX[i] = 0;
            misY[i] = 0;
        end
        park();
        refreshAllDead();
        repeat (16) @(posedge clk);
        #5;
        resetN = 1'b1;

        // Stage 0 keeps the fleet parked and silent
        enable = 1'b1;
        for (int f = 0; f < 2; f++) begin
            runFrame();
            checkFleet();
        end

        // Stage 2 joins four monsters on a frame with motion held off
        enable = 1'b0;
        stage = 2'd2;
        refreshAllDead();
        checkMonster(0);
        runFrame();
        checkFleet();

        enable = 1'b1;
        for (int f = 1; f <= 3; f++) begin
            runFrame();
            checkFleet();
        end
        strike(0);

        // Monster 0 explodes while the rest drift and open fire
        for (int f = 4; f <= 12; f++) begin
            runFrame();
            checkFleet();
        end
        for (int i = 1; i < fleetSize; i++) begin
            strike(i);
        end
        for (int f = 13; f <= 16; f++) begin
            runFrame();
            checkFleet();
        end
        park();
        repeat (4) nextCycle();

        $display("Probes %0d, errors %0d", probeCount, errorCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- logic/displayPkg.sv
// Screen is assumed 640x480 inside an 11-bit coordinate space, colours are fixed 3-3-2 RGB
package displayPkg;

    // Pixel position, used for both X and Y
    typedef logic [10:0] coordinate;

    // 3-3-2 colour word
    typedef struct packed {
        logic [2:0] red;
        logic [2:0] green;
        logic [1:0] blue;
    } rgb;

    // Draw request plus the colour to show when it is granted
    typedef struct packed {
        logic drawReq;
        rgb   color;
    } drawOut;

    // Visible area limits
    localparam coordinate screenWidth  = 11'd640;
    localparam coordinate screenHeight = 11'd480;

    // Fixed palette of the monster layer
    localparam rgb aliveColor   = '{red: 3'd1, green: 3'd6, blue: 2'd1};
    localparam rgb explodeColor = '{red: 3'd7, green: 3'd3, blue: 2'd0};
    localparam rgb missileColor = '{red: 3'd7, green: 3'd7, blue: 2'd0};

endpackage

//--- logic/fleetArbiter.sv
// Overlapping monsters resolve to the lowest index, no steering between them
`timescale 1ns/1ps

module fleetArbiter #(
    parameter int maxMonsters = 4
) (
    input  logic                   clk,
    input  logic                   resetN,
    input  logic [maxMonsters-1:0] drawReqs,
    input  logic [maxMonsters-1:0] hitFlags,
    output logic [maxMonsters-1:0] lastDrawn,
    output displayPkg::drawOut     monsterOut
);
    import displayPkg::*;

    logic anyReq;
    logic chosenHit;

    assign anyReq = |drawReqs;

    // Scan from the top so the lowest requester wins
    always_comb begin
        chosenHit = 1'b0;
        for (int i = maxMonsters - 1; i >= 0; i--) begin
            if (drawReqs[i]) begin
                chosenHit = hitFlags[i];
            end
        end
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            lastDrawn  <= '0;
            monsterOut <= '0;
        end else begin
            lastDrawn          <= drawReqs;
            monsterOut.drawReq <= anyReq;
            monsterOut.color   <= chosenHit ? explodeColor : aliveColor;
        end
    end

    // Collision blame needs a drawn monster behind every drawn pixel
    blameable: assert property (@(posedge clk) disable iff (!resetN)
        monsterOut.drawReq |-> |lastDrawn);

endmodule

//--- logic/fleetPkg.sv
// Fleet constants assume at most 15 monsters per stage and a 16x12 sprite on the display grid
package fleetPkg;

    // Per-monster state, produced by the motion block
    typedef struct packed {
        displayPkg::coordinate topLeftX;
        displayPkg::coordinate topLeftY;
        logic                  hit;
        logic                  active;
    } monsterState;

    // Collision flags from the outside detector
    // Bit 1 flags a player missile, bit 0 flags any screen border
    typedef struct packed {
        logic missileHit;
        logic boundaryHit;
    } collisionVec;

    // Stage selector
    typedef logic [1:0] stageNum;

    // Number of monsters taking part in a stage
    typedef logic [3:0] monsterCount;

    // Stage table, element 0 is stage 0
    localparam monsterCount [3:0] monstersPerStage = {4'd3, 4'd4, 4'd2, 4'd0};

    // Sprite size in pixels
    localparam int monsterW = 16;
    localparam int monsterH = 12;

    // Starting grid, monster i sits at initialX + i * spacingX
    localparam int initialX = 64;
    localparam int initialY = 40;
    localparam int spacingX = 64;

endpackage

//--- logic/monsterFleet.sv
// Stage table must fit maxMonsters, monsters stay parked until a frame starts with a nonzero stage
`timescale 1ns/1ps

module monsterFleet #(
    parameter int maxMonsters = 4,
    parameter int explodeFrames = 3,
    parameter int baseSpeed = 2,
    parameter int baseCooldown = 6,
    parameter int missileSpeed = 4
) (
    input  logic                  clk,
    input  logic                  resetN,
    input  logic                  enable,
    input  logic                  startOfFrame,
    input  displayPkg::coordinate pixelX,
    input  displayPkg::coordinate pixelY,
    input  fleetPkg::stageNum     stage,
    input  fleetPkg::collisionVec collision,
    output displayPkg::drawOut    monsterOut,
    output displayPkg::drawOut    missileOut,
    output logic                  monsterDied,
    output logic                  allDead
);
    import displayPkg::*;
    import fleetPkg::*;

    monsterState [maxMonsters-1:0] states;
    logic [maxMonsters-1:0]        spriteReqs;
    logic [maxMonsters-1:0]        gunReqs;
    logic [maxMonsters-1:0]        lastDrawn;
    logic [maxMonsters-1:0]        hitVec;
    logic [maxMonsters-1:0]        prevHit;
    logic [maxMonsters-1:0]        activeVec;
    monsterCount                   stageCount;
    logic                          armed;
    logic                          fleetLive;
    logic                          frameTick;
    logic                          randomBit;
    logic [15:0]                   lfsr;

    assign stageCount = monstersPerStage[stage];
    assign frameTick  = startOfFrame & enable;

    // The arming frame itself already counts as live
    assign fleetLive = armed | (startOfFrame && stageCount != '0);

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            armed <= 1'b0;
        end else if (startOfFrame && stageCount != '0) begin
            armed <= 1'b1;
        end
    end

    // Galois-free Fibonacci LFSR, taps 16 14 13 11
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            lfsr <= 16'hACE1;
        end else begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    assign randomBit = lfsr[0];

    genvar i;
    generate
        for (i = 0; i < maxMonsters; i++) begin : gMonster
            monsterMotion #(
                .startX       (coordinate'(initialX + i * spacingX)),
                .startY       (coordinate'(initialY)),
                .speed        (baseSpeed),
                .explodeFrames(explodeFrames)
            ) monsterMotion_inst (
                .clk       (clk),
                .resetN    (resetN),
                .frameTick (frameTick),
                .amActive  (fleetLive && (i < int'(stageCount))),
                .missileHit(collision.missileHit & lastDrawn[i]),
                .borderHit (collision.boundaryHit & lastDrawn[i]),
                .randomBit (randomBit),
                .state     (states[i])
            );

            monsterSprite monsterSprite_inst (
                .clk    (clk),
                .resetN (resetN),
                .pixelX (pixelX),
                .pixelY (pixelY),
                .state  (states[i]),
                .drawReq(spriteReqs[i])
            );

            // Staggered cooldowns keep the volleys apart
            monsterGun #(
                .cooldown    (baseCooldown + 2 * i),
                .missileSpeed(missileSpeed)
            ) monsterGun_inst (
                .clk      (clk),
                .resetN   (resetN),
                .frameTick(frameTick),
                .state    (states[i]),
                .farBorder(collision.boundaryHit),
                .pixelX   (pixelX),
                .pixelY   (pixelY),
                .drawReq  (gunReqs[i])
            );

            assign hitVec[i]    = states[i].hit;
            assign activeVec[i] = states[i].active;
        end
    endgenerate

    fleetArbiter #(
        .maxMonsters(maxMonsters)
    ) fleetArbiter_inst (
        .clk       (clk),
        .resetN    (resetN),
        .drawReqs  (spriteReqs),
        .hitFlags  (hitVec),
        .lastDrawn (lastDrawn),
        .monsterOut(monsterOut)
    );

    // One pulse per newly hit monster, a cycle after its hit flag rises
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            prevHit     <= '0;
            monsterDied <= 1'b0;
        end else begin
            prevHit     <= hitVec;
            monsterDied <= |(hitVec & ~prevHit);
        end
    end

    assign allDead = ~|activeVec && (stageCount != '0);

    assign missileOut = '{drawReq: |gunReqs, color: missileColor};

endmodule

//--- logic/monsterGun.sv
// One missile per monster at a time, cooldown must be at least one frame
`timescale 1ns/1ps

module monsterGun #(
    parameter int cooldown = 6,
    parameter int missileSpeed = 4
) (
    input  logic                  clk,
    input  logic                  resetN,
    input  logic                  frameTick,
    input  fleetPkg::monsterState state,
    input  logic                  farBorder,
    input  displayPkg::coordinate pixelX,
    input  displayPkg::coordinate pixelY,
    output logic                  drawReq
);
    import displayPkg::*;
    import fleetPkg::*;

    localparam int missileW = 2;
    localparam int missileH = 6;
    localparam int cdW = $clog2(cooldown + 1);

    logic [cdW-1:0] cdCount;
    logic           expire;
    logic           launch;
    logic           inFlight;
    logic           retire;
    coordinate      missileX;
    coordinate      missileY;
    coordinate      nextY;
    coordinate      offsetX;
    coordinate      offsetY;

    assign expire = frameTick && (cdCount == cdW'(1));
    assign launch = expire && state.active && !state.hit && !inFlight;
    assign nextY  = missileY + coordinate'(missileSpeed);

    // Leaves at the bottom edge or when the detector flags the pixel we just drew
    assign retire = (farBorder && drawReq) || (frameTick && nextY >= screenHeight);

    // Frame cooldown, restarts whenever the monster is out of play
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            cdCount <= cdW'(cooldown);
        end else if (!state.active || expire) begin
            cdCount <= cdW'(cooldown);
        end else if (frameTick) begin
            cdCount <= cdCount - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            inFlight <= 1'b0;
        end else if (launch) begin
            inFlight <= 1'b1;
        end else if (inFlight && retire) begin
            inFlight <= 1'b0;
        end
    end

    // Missile starts centred under the sprite
    always_ff @(posedge clk) begin
        if (launch) begin
            missileX <= state.topLeftX + coordinate'(monsterW / 2 - missileW / 2);
            missileY <= state.topLeftY + coordinate'(monsterH);
        end else if (inFlight && frameTick) begin
            missileY <= nextY;
        end
    end

    assign offsetX = pixelX - missileX;
    assign offsetY = pixelY - missileY;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            drawReq <= 1'b0;
        end else begin
            drawReq <= inFlight && (offsetX < coordinate'(missileW))
                       && (offsetY < coordinate'(missileH));
        end
    end

    // No second launch while a missile is still falling
    noRelaunch: assert property (@(posedge clk) disable iff (!resetN)
        $past(inFlight) && inFlight |-> $stable(missileX));

endmodule

//--- logic/monsterMotion.sv
// Moves on enabled frame ticks only, screen borders are reported from outside and never self-detected
`timescale 1ns/1ps

module monsterMotion #(
    parameter displayPkg::coordinate startX = 11'd0,
    parameter displayPkg::coordinate startY = 11'd0,
    parameter int speed = 2,
    parameter int explodeFrames = 3
) (
    input  logic                  clk,
    input  logic                  resetN,
    input  logic                  frameTick,
    input  logic                  amActive,
    input  logic                  missileHit,
    input  logic                  borderHit,
    input  logic                  randomBit,
    output fleetPkg::monsterState state
);
    import displayPkg::*;
    import fleetPkg::*;

    localparam int countW = $clog2(explodeFrames + 1);

    coordinate         posX;
    coordinate         posY;
    logic              movingRight;
    logic              movingDown;
    logic              hit;
    logic              spent;
    logic              active;
    logic [countW-1:0] explodeCount;

    // Alive in this stage until the explosion has played out
    assign active = amActive & ~spent;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            posX         <= startX;
            posY         <= startY;
            movingRight  <= 1'b1;
            movingDown   <= 1'b1;
            hit          <= 1'b0;
            spent        <= 1'b0;
            explodeCount <= '0;
        end else if (!amActive) begin
            // Not part of the stage, wait at the start slot
            posX         <= startX;
            posY         <= startY;
            movingRight  <= 1'b1;
            movingDown   <= 1'b1;
            hit          <= 1'b0;
            spent        <= 1'b0;
            explodeCount <= '0;
        end else if (hit) begin
            // Position frozen, count explosion frames down
            if (frameTick && !spent) begin
                if (explodeCount <= countW'(1)) begin
                    spent <= 1'b1;
                end
                explodeCount <= explodeCount - 1'b1;
            end
        end else if (missileHit) begin
            hit          <= 1'b1;
            explodeCount <= countW'(explodeFrames);
        end else begin
            // Bounce flips X, new Y direction is a coin toss
            if (borderHit) begin
                movingRight <= ~movingRight;
                movingDown  <= randomBit;
            end
            if (frameTick) begin
                posX <= movingRight ? posX + coordinate'(speed) : posX - coordinate'(speed);
                posY <= movingDown ? posY + coordinate'(speed) : posY - coordinate'(speed);
            end
        end
    end

    assign state = '{topLeftX: posX, topLeftY: posY, hit: hit, active: active};

    // A monster outside the stage or already exploded can never be struck
    hitNeedsActive: assert property (@(posedge clk) disable iff (!resetN)
        $rose(hit) |-> $past(active));

endmodule

//--- logic/monsterSprite.sv
// Draw test assumes the sprite box is at least 4x4 so the clipped corners never overlap
`timescale 1ns/1ps

module monsterSprite (
    input  logic                  clk,
    input  logic                  resetN,
    input  displayPkg::coordinate pixelX,
    input  displayPkg::coordinate pixelY,
    input  fleetPkg::monsterState state,
    output logic                  drawReq
);
    import displayPkg::*;
    import fleetPkg::*;

    coordinate offsetX;
    coordinate offsetY;
    logic      insideBox;
    logic      onScreen;
    logic      cornerX;
    logic      cornerY;

    // Unsigned wrap makes pixels left of or above the box look far away
    assign offsetX = pixelX - state.topLeftX;
    assign offsetY = pixelY - state.topLeftY;

    assign insideBox = (offsetX < coordinate'(monsterW)) && (offsetY < coordinate'(monsterH));

    // Blanking region never draws
    assign onScreen = (pixelX < screenWidth) && (pixelY < screenHeight);

    // Silhouette drops a 2x2 square at each corner
    assign cornerX = (offsetX < coordinate'(2)) || (offsetX >= coordinate'(monsterW - 2));
    assign cornerY = (offsetY < coordinate'(2)) || (offsetY >= coordinate'(monsterH - 2));

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            drawReq <= 1'b0;
        end else begin
            drawReq <= state.active & onScreen & insideBox & ~(cornerX & cornerY);
        end
    end

endmodule

//--- project.f
logic/displayPkg.sv
logic/fleetPkg.sv
logic/monsterMotion.sv
logic/monsterSprite.sv
logic/monsterGun.sv
logic/fleetArbiter.sv
logic/monsterFleet.sv
dv/fleetTb.sv
